// File: Bender.yml
package:
  name: imuldiv

sources:
  - imuldiv_msg_pkg.sv
  - imuldiv_ctrl_pkg.sv
  - imuldiv_req_if.sv
  - imuldiv_iter_ctrl.sv
  - imuldiv_mul_dpath.sv
  - imuldiv_div_dpath.sv
  - imuldiv_front.sv
  - imuldiv_top.sv
  - target: test
    files:
      - imuldiv_asserts.sv
      - tb_imuldiv.sv

// File: imuldiv_asserts.sv
/*
 * handshake assertions for the multiply/divide top level attached by bind
 */
module imuldiv_asserts #(
  parameter int WIDTH = 32
) (
  input logic                          clk,
  input logic                          reset,
  input logic                          resp_val,
  input logic                          resp_rdy,
  input imuldiv_msg_pkg::muldiv_fn_e   resp_fn,
  input logic [2*WIDTH-1:0]            resp_result,
  input imuldiv_msg_pkg::unit_sel_e    head_unit,
  input imuldiv_ctrl_pkg::iter_state_e mul_state,
  input imuldiv_ctrl_pkg::iter_state_e div_state
);

  timeunit 1ns;
  timeprecision 1ps;

  // a stalled response keeps all of its fields
  resp_stable: assert property (@(posedge clk) disable iff (reset)
    (resp_val && !resp_rdy) |=> (resp_val && $stable(resp_fn) && $stable(resp_result)))
    else $error("response changed while stalled");

  // nothing is pending once reset has been applied
  resp_low_after_reset: assert property (@(posedge clk) reset |=> !resp_val)
    else $error("resp_val high after reset");

  // a controller leaves DONE only on a top-level transfer of its own response
  mul_done_hold: assert property (@(posedge clk) disable iff (reset)
    (mul_state == imuldiv_ctrl_pkg::DONE &&
     !(resp_val && resp_rdy && head_unit == imuldiv_msg_pkg::UNIT_MUL))
    |=> mul_state == imuldiv_ctrl_pkg::DONE)
    else $error("multiply controller left DONE without a transfer");

  div_done_hold: assert property (@(posedge clk) disable iff (reset)
    (div_state == imuldiv_ctrl_pkg::DONE &&
     !(resp_val && resp_rdy && head_unit == imuldiv_msg_pkg::UNIT_DIV))
    |=> div_state == imuldiv_ctrl_pkg::DONE)
    else $error("divide controller left DONE without a transfer");

endmodule

bind imuldiv_top imuldiv_asserts #(.WIDTH(WIDTH)) asserts0 (
  .clk          (clk),
  .reset        (reset),
  .resp_val     (resp_val),
  .resp_rdy     (resp_rdy),
  .resp_fn      (resp_fn),
  .resp_result  (resp_result),
  .head_unit    (front.head_unit),
  .mul_state    (mul_ctrl.state),
  .div_state    (div_ctrl.state)
);

// File: imuldiv_ctrl_pkg.sv
/*
 * imuldiv iteration control definitions
 * state encoding and step counter sizing shared by both units
 */
package imuldiv_ctrl_pkg;

  // one operation walks IDLE -> CALC -> FIX -> DONE -> IDLE
  typedef enum logic [1:0] {
    IDLE = 2'd0,
    CALC = 2'd1,
    FIX  = 2'd2,
    DONE = 2'd3
  } iter_state_e;

  // counter runs 0 .. width-1, one value per step
  // at least one bit so a tiny width still builds
  function automatic int step_cnt_bits(int width);
    int bits;
    bits = $clog2(width);
    if (bits < 1) begin
      bits = 1;
    end
    return bits;
  endfunction

endpackage

// File: imuldiv_div_dpath.sv
/*
 * divide datapath
 * restoring shift-subtract on magnitudes, then sign and divide-by-zero fix
 */
module imuldiv_div_dpath #(
  parameter int WIDTH = 32
) (
  input  logic         clk,
  input  logic         reset,
  imuldiv_req_if.dpath req,
  input  logic         load,
  input  logic         step,
  input  logic         fix
);

  localparam int RW = 2 * WIDTH;

  logic [WIDTH-1:0] a_mag;
  logic [WIDTH-1:0] b_mag;
  logic [WIDTH-1:0] rem_q;
  logic [WIDTH-1:0] quot_q;
  logic [WIDTH-1:0] dvsr_q;
  logic [WIDTH-1:0] dvnd_q;
  logic             sign_a_q;
  logic             sign_b_q;
  logic             dz_q;
  logic [WIDTH:0]   shifted;
  logic [WIDTH:0]   diff;
  logic [WIDTH-1:0] quot_fix;
  logic [WIDTH-1:0] rem_fix;
  logic [RW-1:0]    result_q;

  assign a_mag = (req.op_signed && req.a[WIDTH-1]) ? -req.a : req.a;
  assign b_mag = (req.op_signed && req.b[WIDTH-1]) ? -req.b : req.b;

  //------------------------------------------------------------
  // restoring step
  //------------------------------------------------------------

  // remainder picks up the next dividend bit from the quotient msb
  assign shifted = {rem_q, quot_q[WIDTH-1]};
  // one extra bit so a borrow shows up as diff msb
  assign diff    = shifted - {1'b0, dvsr_q};

  always_ff @(posedge clk) begin
    if (load) begin
      rem_q    <= '0;
      quot_q   <= a_mag;
      dvsr_q   <= b_mag;
      dvnd_q   <= req.a;
      sign_a_q <= req.op_signed && req.a[WIDTH-1];
      sign_b_q <= req.op_signed && req.b[WIDTH-1];
      dz_q     <= (req.b == '0);
    end else if (step) begin
      // keep the difference only when it did not go negative
      rem_q  <= diff[WIDTH] ? shifted[WIDTH-1:0] : diff[WIDTH-1:0];
      quot_q <= {quot_q[WIDTH-2:0], ~diff[WIDTH]};
    end
  end

  //------------------------------------------------------------
  // sign rules
  //------------------------------------------------------------

  // quotient negative when signs differ, remainder follows the dividend
  // most negative / -1 wraps back to the dividend through the negate
  assign quot_fix = (sign_a_q ^ sign_b_q) ? -quot_q : quot_q;
  assign rem_fix  = sign_a_q ? -rem_q : rem_q;

  always_ff @(posedge clk) begin
    if (reset) begin
      result_q <= '0;
    end else if (fix) begin
      if (dz_q) begin
        // divide by zero: all ones quotient, dividend back as remainder
        result_q <= {dvnd_q, {WIDTH{1'b1}}};
      end else begin
        result_q <= {rem_fix, quot_fix};
      end
    end
  end

  // remainder in the upper half, quotient in the lower half
  assign req.result = result_q;

endmodule

// File: imuldiv_front.sv
/*
 * imuldiv front end
 * steers requests by operation and returns responses in request order
 */
module imuldiv_front #(
  parameter int WIDTH = 32
) (
  input  logic                            clk,
  input  logic                            reset,
  input  logic                            req_val,
  output logic                            req_rdy,
  input  imuldiv_msg_pkg::muldiv_fn_e     req_fn,
  input  logic [WIDTH-1:0]                req_a,
  input  logic [WIDTH-1:0]                req_b,
  output logic                            resp_val,
  input  logic                            resp_rdy,
  output imuldiv_msg_pkg::muldiv_fn_e     resp_fn,
  output logic [2*WIDTH-1:0]              resp_result,
  imuldiv_req_if.front                    mul,
  imuldiv_req_if.front                    div
);

  imuldiv_msg_pkg::unit_sel_e  sel_unit;
  logic                        sel_signed;
  logic                        sel_rdy;
  logic                        push;
  logic                        pop;
  logic                        full;
  logic                        empty;
  // order queue, two entries cover one operation per unit
  imuldiv_msg_pkg::unit_sel_e  q_unit [2];
  imuldiv_msg_pkg::muldiv_fn_e q_fn [2];
  logic                        wr_ptr;
  logic                        rd_ptr;
  logic [1:0]                  cnt;
  imuldiv_msg_pkg::unit_sel_e  head_unit;

  //------------------------------------------------------------
  // request steering
  //------------------------------------------------------------

  assign sel_unit   = imuldiv_msg_pkg::fn_unit(req_fn);
  assign sel_signed = imuldiv_msg_pkg::fn_signed(req_fn);
  assign sel_rdy    = (sel_unit == imuldiv_msg_pkg::UNIT_DIV) ? div.rdy : mul.rdy;

  // no unit may start unless its order slot can be recorded
  assign mul.val       = req_val && !full && (sel_unit == imuldiv_msg_pkg::UNIT_MUL);
  assign div.val       = req_val && !full && (sel_unit == imuldiv_msg_pkg::UNIT_DIV);
  assign mul.a         = req_a;
  assign mul.b         = req_b;
  assign div.a         = req_a;
  assign div.b         = req_b;
  assign mul.op_signed = sel_signed;
  assign div.op_signed = sel_signed;
  assign req_rdy       = sel_rdy && !full;
  assign push          = req_val && req_rdy;

  //------------------------------------------------------------
  // order queue
  //------------------------------------------------------------

  assign full  = (cnt == 2'd2);
  assign empty = (cnt == 2'd0);

  always_ff @(posedge clk) begin
    if (push) begin
      q_unit[wr_ptr] <= sel_unit;
      q_fn[wr_ptr]   <= req_fn;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= 1'b0;
      rd_ptr <= 1'b0;
      cnt    <= 2'd0;
    end else begin
      if (push) wr_ptr <= ~wr_ptr;
      if (pop) rd_ptr <= ~rd_ptr;
      // both at once leaves the depth unchanged
      if (push && !pop) begin
        cnt <= cnt + 2'd1;
      end else if (pop && !push) begin
        cnt <= cnt - 2'd1;
      end
    end
  end

  //------------------------------------------------------------
  // response select, oldest request first
  //------------------------------------------------------------

  assign head_unit    = q_unit[rd_ptr];
  assign resp_fn      = q_fn[rd_ptr];
  assign resp_val     = !empty && ((head_unit == imuldiv_msg_pkg::UNIT_DIV) ?
                                   div.resp_val : mul.resp_val);
  assign resp_result  = (head_unit == imuldiv_msg_pkg::UNIT_DIV) ? div.result : mul.result;
  assign mul.resp_rdy = resp_rdy && !empty && (head_unit == imuldiv_msg_pkg::UNIT_MUL);
  assign div.resp_rdy = resp_rdy && !empty && (head_unit == imuldiv_msg_pkg::UNIT_DIV);
  assign pop          = resp_val && resp_rdy;

endmodule

// File: imuldiv_iter_ctrl.sv
/*
 * iterative unit controller
 * accepts one operation, sequences WIDTH steps and a sign fix, holds the response
 */
module imuldiv_iter_ctrl #(
  parameter int WIDTH = 32
) (
  input  logic        clk,
  input  logic        reset,
  imuldiv_req_if.ctrl req,
  output logic        load,
  output logic        step,
  output logic        fix
);

  localparam int CNT_W = imuldiv_ctrl_pkg::step_cnt_bits(WIDTH);
  localparam logic [CNT_W-1:0] LAST_STEP = CNT_W'(WIDTH - 1);

  imuldiv_ctrl_pkg::iter_state_e state;
  imuldiv_ctrl_pkg::iter_state_e state_next;
  logic [CNT_W-1:0]              count;
  logic                          accept;
  logic                          resp_done;

  // handshake events
  assign accept    = req.val && (state == imuldiv_ctrl_pkg::IDLE);
  assign resp_done = req.resp_rdy && (state == imuldiv_ctrl_pkg::DONE);

  //------------------------------------------------------------
  // state and step counter
  //------------------------------------------------------------

  always_comb begin
    state_next = state;
    unique case (state)
      imuldiv_ctrl_pkg::IDLE: if (accept) state_next = imuldiv_ctrl_pkg::CALC;
      // last step moves on to the sign fix
      imuldiv_ctrl_pkg::CALC: if (count == LAST_STEP) state_next = imuldiv_ctrl_pkg::FIX;
      imuldiv_ctrl_pkg::FIX:  state_next = imuldiv_ctrl_pkg::DONE;
      imuldiv_ctrl_pkg::DONE: if (resp_done) state_next = imuldiv_ctrl_pkg::IDLE;
      default:                state_next = imuldiv_ctrl_pkg::IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= imuldiv_ctrl_pkg::IDLE;
      count <= '0;
    end else begin
      state <= state_next;
      // restart the count on accept, advance once per step
      if (accept) begin
        count <= '0;
      end else if (state == imuldiv_ctrl_pkg::CALC) begin
        count <= count + 1'b1;
      end
    end
  end

  //------------------------------------------------------------
  // strobes and handshake outputs
  //------------------------------------------------------------

  // load fires on the accepting edge itself
  assign load         = accept;
  assign step         = (state == imuldiv_ctrl_pkg::CALC);
  assign fix          = (state == imuldiv_ctrl_pkg::FIX);
  assign req.rdy      = (state == imuldiv_ctrl_pkg::IDLE);
  assign req.resp_val = (state == imuldiv_ctrl_pkg::DONE);

endmodule

// File: imuldiv_msg_pkg.sv
/*
 * imuldiv message definitions
 * operation codes and decode helpers for the request stream
 */
package imuldiv_msg_pkg;

  // operation code carried with each request and echoed with its response
  typedef enum logic [1:0] {
    FN_MUL  = 2'd0,
    FN_MULU = 2'd1,
    FN_DIV  = 2'd2,
    FN_DIVU = 2'd3
  } muldiv_fn_e;

  // which iterative unit serves a request
  typedef enum logic {
    UNIT_MUL = 1'b0,
    UNIT_DIV = 1'b1
  } unit_sel_e;

  // divides go to the divide unit, everything else multiplies
  function automatic unit_sel_e fn_unit(muldiv_fn_e fn);
    return (fn == FN_DIV || fn == FN_DIVU) ? UNIT_DIV : UNIT_MUL;
  endfunction

  // signed ops treat operand msb as a sign bit
  function automatic logic fn_signed(muldiv_fn_e fn);
    return (fn == FN_MUL || fn == FN_DIV);
  endfunction

endpackage

// File: imuldiv_mul_dpath.sv
/*
 * multiply datapath
 * shift-and-add on operand magnitudes, product sign fixed at the end
 */
module imuldiv_mul_dpath #(
  parameter int WIDTH = 32
) (
  input  logic         clk,
  input  logic         reset,
  imuldiv_req_if.dpath req,
  input  logic         load,
  input  logic         step,
  input  logic         fix
);

  localparam int RW = 2 * WIDTH;

  logic [WIDTH-1:0] a_mag;
  logic [WIDTH-1:0] b_mag;
  logic [RW-1:0]    mcand_q;
  logic [WIDTH-1:0] mplier_q;
  logic [RW-1:0]    acc_q;
  logic             neg_q;
  logic [RW-1:0]    result_q;

  // magnitudes only differ from the raw operand for negative signed inputs
  assign a_mag = (req.op_signed && req.a[WIDTH-1]) ? -req.a : req.a;
  assign b_mag = (req.op_signed && req.b[WIDTH-1]) ? -req.b : req.b;

  //------------------------------------------------------------
  // shift-and-add iteration
  //------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (load) begin
      mcand_q  <= {{WIDTH{1'b0}}, a_mag};
      mplier_q <= b_mag;
      acc_q    <= '0;
      // product is negative when exactly one signed operand is negative
      neg_q    <= req.op_signed && (req.a[WIDTH-1] ^ req.b[WIDTH-1]);
    end else if (step) begin
      // add the shifted multiplicand for each set multiplier bit
      if (mplier_q[0]) begin
        acc_q <= acc_q + mcand_q;
      end
      mcand_q  <= mcand_q << 1;
      mplier_q <= mplier_q >> 1;
    end
  end

  //------------------------------------------------------------
  // sign fix into the result register
  //------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      result_q <= '0;
    end else if (fix) begin
      result_q <= neg_q ? -acc_q : acc_q;
    end
  end

  // held stable through DONE until the response transfers
  assign req.result = result_q;

endmodule

// File: imuldiv_req_if.sv
/*
 * request/response bundle between the front end and one iterative unit
 */
interface imuldiv_req_if #(
  parameter int WIDTH = 32
) ();

  // request side
  logic               val;
  logic               rdy;
  logic [WIDTH-1:0]   a;
  logic [WIDTH-1:0]   b;
  logic               op_signed;

  // response side
  logic               resp_val;
  logic               resp_rdy;
  logic [2*WIDTH-1:0] result;

  // front end steers requests in and collects responses
  modport front (
    output val, a, b, op_signed, resp_rdy,
    input  rdy, resp_val, result
  );

  // controller owns the handshake only
  modport ctrl (
    input  val, resp_rdy,
    output rdy, resp_val
  );

  // datapath sees operands, produces the result
  modport dpath (
    input  a, b, op_signed,
    output result
  );

endinterface

// File: imuldiv_stim.txt
// columns: fn a b expected_result issue_gap resp_hold, all hex
// fn 0 mul, 1 mulu, 2 div, 3 divu; divide result is {remainder, quotient}
14
0 00000007 fffffffd ffffffffffffffeb 2 0
1 ffffffff ffffffff fffffffe00000001 0 3
0 80000000 80000000 4000000000000000 1 0
0 00000000 12345678 0000000000000000 0 5
1 80000000 00000002 0000000100000000 3 0
0 7fffffff 80000000 c000000080000000 0 2
2 fffffff9 00000002 fffffffffffffffd 0 0
2 00000007 fffffffe 00000001fffffffd 1 4
3 ffffffff 00000010 0000000f0fffffff 0 0
2 00000064 00000007 000000020000000e 2 1
2 fffffff6 00000000 fffffff6ffffffff 0 0
3 00001234 00000000 00001234ffffffff 0 6
2 80000000 ffffffff 0000000080000000 1 0
3 80000000 ffffffff 8000000000000000 0 2
2 000003e8 00000003 000000010000014d 0 0
0 fffffffe fffffffe 0000000000000004 0 7
1 12345678 00000010 0000000123456780 2 0
2 80000000 00000001 0000000080000000 0 3
3 deadbeef 00010000 0000beef0000dead 0 0
0 ffffffff 00000001 ffffffffffffffff 0 1

// File: imuldiv_top.sv
/*
 * iterative integer multiply/divide unit, top level
 */
module imuldiv_top #(
  parameter int WIDTH = 32
) (
  input  logic                        clk,
  input  logic                        reset,
  // request channel
  input  logic                        req_val,
  output logic                        req_rdy,
  input  imuldiv_msg_pkg::muldiv_fn_e req_fn,
  input  logic [WIDTH-1:0]            req_a,
  input  logic [WIDTH-1:0]            req_b,
  // response channel
  output logic                        resp_val,
  input  logic                        resp_rdy,
  output imuldiv_msg_pkg::muldiv_fn_e resp_fn,
  output logic [2*WIDTH-1:0]          resp_result
);

  // per-unit strobes from controller to datapath
  logic mul_load;
  logic mul_step;
  logic mul_fix;
  logic div_load;
  logic div_step;
  logic div_fix;

  imuldiv_req_if #(.WIDTH(WIDTH)) mul_if ();
  imuldiv_req_if #(.WIDTH(WIDTH)) div_if ();

  imuldiv_front #(.WIDTH(WIDTH)) front (
    .clk         (clk),
    .reset       (reset),
    .req_val     (req_val),
    .req_rdy     (req_rdy),
    .req_fn      (req_fn),
    .req_a       (req_a),
    .req_b       (req_b),
    .resp_val    (resp_val),
    .resp_rdy    (resp_rdy),
    .resp_fn     (resp_fn),
    .resp_result (resp_result),
    .mul         (mul_if.front),
    .div         (div_if.front)
  );

  //------------------------------------------------------------
  // multiply unit
  //------------------------------------------------------------

  imuldiv_iter_ctrl #(.WIDTH(WIDTH)) mul_ctrl (
    .clk   (clk),
    .reset (reset),
    .req   (mul_if.ctrl),
    .load  (mul_load),
    .step  (mul_step),
    .fix   (mul_fix)
  );

  imuldiv_mul_dpath #(.WIDTH(WIDTH)) mul_dpath (
    .clk   (clk),
    .reset (reset),
    .req   (mul_if.dpath),
    .load  (mul_load),
    .step  (mul_step),
    .fix   (mul_fix)
  );

  //------------------------------------------------------------
  // divide unit
  //------------------------------------------------------------

  imuldiv_iter_ctrl #(.WIDTH(WIDTH)) div_ctrl (
    .clk   (clk),
    .reset (reset),
    .req   (div_if.ctrl),
    .load  (div_load),
    .step  (div_step),
    .fix   (div_fix)
  );

  imuldiv_div_dpath #(.WIDTH(WIDTH)) div_dpath (
    .clk   (clk),
    .reset (reset),
    .req   (div_if.dpath),
    .load  (div_load),
    .step  (div_step),
    .fix   (div_fix)
  );

endmodule

// File: project.f
imuldiv_msg_pkg.sv
imuldiv_ctrl_pkg.sv
imuldiv_req_if.sv
imuldiv_iter_ctrl.sv
imuldiv_mul_dpath.sv
imuldiv_div_dpath.sv
imuldiv_front.sv
imuldiv_top.sv
imuldiv_asserts.sv
tb_imuldiv.sv

// File: tb_imuldiv.sv
/*
 * testbench for the multiply/divide unit
 * file-driven requests and in-order response checking under back-pressure
 */
module tb_imuldiv;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int WIDTH     = 32;
  localparam int NUM_VEC   = 20;
  localparam int NUM_WORDS = 1 + 6 * NUM_VEC;
  localparam int TIMEOUT   = 500;
  localparam int PERIOD    = 8;

  logic                        clk;
  logic                        reset;
  logic                        req_val;
  logic                        req_rdy;
  imuldiv_msg_pkg::muldiv_fn_e req_fn;
  logic [WIDTH-1:0]            req_a;
  logic [WIDTH-1:0]            req_b;
  logic                        resp_val;
  logic                        resp_rdy;
  imuldiv_msg_pkg::muldiv_fn_e resp_fn;
  logic [2*WIDTH-1:0]          resp_result;

  // word 0 holds the vector count and six words follow per vector
  logic [63:0] vec_mem [0:NUM_WORDS-1];
  // expected responses in issue order
  logic [1:0]  exp_fn_q [$];
  logic [63:0] exp_res_q [$];
  int          exp_hold_q [$];
  // accepting edge of each outstanding request
  time         exp_acc_q [$];
  // outstanding requests per unit with the divider at index 1
  int          busy [2];
  int          n_resp;
  integer      seed;

  imuldiv_top #(.WIDTH(WIDTH)) dut0 (
    .clk         (clk),
    .reset       (reset),
    .req_val     (req_val),
    .req_rdy     (req_rdy),
    .req_fn      (req_fn),
    .req_a       (req_a),
    .req_b       (req_b),
    .resp_val    (resp_val),
    .resp_rdy    (resp_rdy),
    .resp_fn     (resp_fn),
    .resp_result (resp_result)
  );

  initial begin
    clk = 1'b0;
    forever #(PERIOD / 2) clk = ~clk;
  end

  //------------------------------------------------------------
  // failure reporting
  //------------------------------------------------------------

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("Testbench failed");
    $fatal(1, "simulation stopped on first error");
  endtask

  task automatic check(input string name, input logic [63:0] got, input logic [63:0] expected);
    if (got !== expected) begin
      fail_run($sformatf("mismatch at %0t: %s got %h expected %h", $time, name, got, expected));
    end
  endtask

  task automatic report_timeout(input string what);
    fail_run($sformatf("timeout after %0d cycles waiting for %s", TIMEOUT, what));
  endtask

  //------------------------------------------------------------
  // stimulus
  //------------------------------------------------------------

  task automatic load_vectors();
    $readmemh("imuldiv_stim.txt", vec_mem);
    check("vector count", vec_mem[0], NUM_VEC);
    if ($isunknown(vec_mem[NUM_WORDS-1])) begin
      fail_run("stimulus file is shorter than expected");
    end
  endtask

  // divide codes run on the divide unit
  function automatic int unit_of(input logic [1:0] fn);
    return (fn == imuldiv_msg_pkg::FN_DIV || fn == imuldiv_msg_pkg::FN_DIVU) ? 1 : 0;
  endfunction

  // issue every vector and record its expected response
  task automatic drive_requests();
    int base;
    int waited;
    int unit;
    for (int v = 0; v < NUM_VEC; v++) begin
      base    = 1 + v * 6;
      unit    = unit_of(vec_mem[base][1:0]);
      req_val = 1'b1;
      req_fn  = imuldiv_msg_pkg::muldiv_fn_e'(vec_mem[base][1:0]);
      req_a   = vec_mem[base+1][WIDTH-1:0];
      req_b   = vec_mem[base+2][WIDTH-1:0];
      // req_rdy settles within the low phase
      #1;
      waited = 0;
      // a busy unit stalls its own requests and no others
      while (busy[unit] != 0) begin
        if (waited >= TIMEOUT) report_timeout("the target unit to free up");
        check("req_rdy", req_rdy, 0);
        @(negedge clk);
        #1;
        waited++;
      end
      check("req_rdy", req_rdy, 1);
      exp_fn_q.push_back(vec_mem[base][1:0]);
      exp_res_q.push_back(vec_mem[base+3]);
      exp_hold_q.push_back(int'(vec_mem[base+5]));
      @(posedge clk);
      busy[unit]++;
      exp_acc_q.push_back($time);
      @(negedge clk);
      req_val = 1'b0;
      repeat (int'(vec_mem[base+4])) @(negedge clk);
    end
  endtask

  //------------------------------------------------------------
  // response side with back-pressure
  //------------------------------------------------------------

  task automatic collect_responses();
    int          waited;
    int          hold;
    time         rise_time;
    time         last_xfer;
    logic [63:0] held_result;
    logic [1:0]  held_fn;
    logic [1:0]  fn_exp;
    last_xfer = 0;
    while (n_resp < NUM_VEC) begin
      waited = 0;
      while (!resp_val) begin
        if (waited >= TIMEOUT) report_timeout("resp_val");
        @(negedge clk);
        waited++;
      end
      if (exp_res_q.size() == 0) begin
        fail_run("response arrived with no request outstanding");
      end
      // visible WIDTH+1 edges after acceptance or right after the older response leaves
      rise_time = exp_acc_q.pop_front() + (WIDTH + 1) * PERIOD;
      if (last_xfer > rise_time) begin
        rise_time = last_xfer;
      end
      check("resp_val rise time", $time, rise_time + PERIOD / 2);
      // stall for the file's count plus a little random extra
      hold        = exp_hold_q.pop_front() + ($random(seed) & 3);
      held_result = resp_result;
      held_fn     = resp_fn;
      for (int i = 0; i < hold; i++) begin
        @(negedge clk);
        check("resp_val", resp_val, 1);
        check("resp_fn", resp_fn, held_fn);
        check("resp_result", resp_result, held_result);
      end
      fn_exp   = exp_fn_q.pop_front();
      resp_rdy = 1'b1;
      check("resp_fn", resp_fn, fn_exp);
      check("resp_result", resp_result, exp_res_q.pop_front());
      @(posedge clk);
      last_xfer = $time;
      busy[unit_of(fn_exp)]--;
      n_resp++;
      @(negedge clk);
      resp_rdy = 1'b0;
    end
  endtask

  //------------------------------------------------------------
  // main sequence
  //------------------------------------------------------------

  initial begin
    seed     = 32'h0538_a15f;
    reset    = 1'b1;
    req_val  = 1'b0;
    req_fn   = imuldiv_msg_pkg::FN_MUL;
    req_a    = '0;
    req_b    = '0;
    resp_rdy = 1'b0;
    n_resp   = 0;
    busy[0]  = 0;
    busy[1]  = 0;
    load_vectors();
    repeat (5) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    #1;
    // idle state straight out of reset
    check("resp_val", resp_val, 0);
    check("req_rdy", req_rdy, 1);
    @(negedge clk);
    fork
      drive_requests();
      collect_responses();
    join
    // a repeated response would show up here
    for (int i = 0; i < 40; i++) begin
      @(negedge clk);
      check("resp_val", resp_val, 0);
    end
    $display("Testbench passed");
    $finish;
  end

endmodule
